// File: logic/armleocpu_defs_pkg.sv
package armleocpu_defs_pkg;

    // load types as driven by the core
    typedef enum logic [2:0] {
        LOAD_BYTE          = 3'd0,
        LOAD_BYTE_UNSIGNED = 3'd1,
        LOAD_HALF          = 3'd2,
        LOAD_HALF_UNSIGNED = 3'd3,
        LOAD_WORD          = 3'd4
    } load_type_t;

    // store types as driven by the core
    typedef enum logic [1:0] {
        STORE_BYTE = 2'd0,
        STORE_HALF = 2'd1,
        STORE_WORD = 2'd2
    } store_type_t;

    // line geometry, 16 words of 32 bits = 64 bytes
    localparam int OFFSET_W   = 4;
    localparam int LINE_WORDS = 16;

    // physical tag width
    localparam int TAG_W = 22;

    // lane field width of the address layout below
    // the cache parameter LANES_W has to equal this value
    localparam int LANE_W = 4;

    // request address, seen either as a plain word or split into fields
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [TAG_W-1:0]    tag;
            logic [LANE_W-1:0]   lane;
            logic [OFFSET_W-1:0] offset;
            logic [1:0]          inword;
        } f;
    } cache_addr_u;

endpackage

// File: logic/mem_1w1r.sv
`timescale 1ns/10ps

module mem_1w1r #(
    parameter int ELEMENTS_W = 4,
    parameter int WIDTH      = 32
) (
    input  logic                  clk,

    input  logic                  read,
    input  logic [ELEMENTS_W-1:0] readaddress,
    output logic [WIDTH-1:0]      readdata,

    input  logic                  write,
    input  logic [ELEMENTS_W-1:0] writeaddress,
    input  logic [WIDTH-1:0]      writedata
);

    logic [WIDTH-1:0] storage [2**ELEMENTS_W];

    always_ff @(posedge clk) begin
        if (write) begin
            storage[writeaddress] <= writedata;
        end
    end

    // registered read, same-address write shows up one cycle later
    always_ff @(posedge clk) begin
        if (read) begin
            readdata <= storage[readaddress];
        end
    end

endmodule

// File: logic/cache_load_align.sv
`timescale 1ns/10ps

module cache_load_align import armleocpu_defs_pkg::*; (
    input  logic [31:0] word,
    input  logic [1:0]  inword,
    input  load_type_t  load_type,
    output logic [31:0] data,
    output logic        misaligned
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // byte and half picked by the low address bits
    assign byte_sel = word[{inword, 3'b000} +: 8];
    assign half_sel = inword[1] ? word[31:16] : word[15:0];

    always_comb begin
        data       = word;
        misaligned = 1'b0;
        case (load_type)
            LOAD_BYTE: begin
                data = {{24{byte_sel[7]}}, byte_sel};
            end
            LOAD_BYTE_UNSIGNED: begin
                data = {24'd0, byte_sel};
            end
            LOAD_HALF: begin
                data       = {{16{half_sel[15]}}, half_sel};
                misaligned = inword[0];
            end
            LOAD_HALF_UNSIGNED: begin
                data       = {16'd0, half_sel};
                misaligned = inword[0];
            end
            LOAD_WORD: begin
                data       = word;
                misaligned = |inword;
            end
            default: begin
                data       = word;
                misaligned = 1'b0;
            end
        endcase
    end

endmodule

// File: logic/cache_store_merge.sv
`timescale 1ns/10ps

module cache_store_merge import armleocpu_defs_pkg::*; (
    input  logic [31:0] old_word,
    input  logic [31:0] store_data,
    input  logic [1:0]  inword,
    input  store_type_t store_type,
    output logic [31:0] new_word,
    output logic        misaligned
);

    always_comb begin
        new_word   = old_word;
        misaligned = 1'b0;
        case (store_type)
            STORE_BYTE: begin
                new_word[{inword, 3'b000} +: 8] = store_data[7:0];
            end
            STORE_HALF: begin
                misaligned = inword[0];
                if (inword[1]) begin
                    new_word[31:16] = store_data[15:0];
                end else begin
                    new_word[15:0] = store_data[15:0];
                end
            end
            STORE_WORD: begin
                misaligned = |inword;
                new_word   = store_data;
            end
            default: begin
                new_word   = old_word;
                misaligned = 1'b0;
            end
        endcase
    end

endmodule

// File: logic/armleocpu_cache.sv
`timescale 1ns/10ps

module armleocpu_cache import armleocpu_defs_pkg::*; #(
    parameter int WAYS_W  = 2,
    parameter int LANES_W = 4
) (
    input  logic        clk,
    input  logic        rst_n,

    // core side
    input  logic [31:0] c_address,
    output logic        c_wait,
    output logic        c_accessfault,
    output logic        c_done,
    input  logic        c_load,
    input  load_type_t  c_load_type,
    output logic [31:0] c_load_data,
    input  logic        c_store,
    input  store_type_t c_store_type,
    input  logic [31:0] c_store_data,
    input  logic        c_flush,
    output logic        c_flushing,
    output logic        c_flush_done,

    // memory side
    output logic [31:0] m_address,
    input  logic        m_waitrequest,
    output logic        m_read,
    input  logic [31:0] m_readdata,
    input  logic        m_readdatavalid,
    output logic        m_write,
    output logic [31:0] m_writedata
);

    localparam int WAYS  = 2**WAYS_W;
    localparam int LANES = 2**LANES_W;
    localparam logic [OFFSET_W-1:0] LAST_BEAT = OFFSET_W'(LINE_WORDS - 1);

    localparam logic [2:0] STATE_IDLE      = 3'd0,
                           STATE_LOOKUP    = 3'd1,
                           STATE_WRITEBACK = 3'd2,
                           STATE_REFILL    = 3'd3,
                           STATE_FLUSH_ALL = 3'd4;

    logic [2:0]                    state;
    logic [WAYS-1:0][LANES-1:0]    valid;
    logic [WAYS-1:0][LANES-1:0]    dirty;
    logic                          flush_pending;
    logic [WAYS_W-1:0]             victim_way;
    logic [OFFSET_W-1:0]           beat;
    logic                          wb_primed;
    logic                          cmd_sent;
    logic                          refill_done;
    logic                          flush_rd;
    logic [LANES_W+WAYS_W-1:0]     flush_idx;

    // line being written back
    logic [TAG_W-1:0]              wb_tag;
    logic [LANES_W-1:0]            wb_lane;
    logic [WAYS_W-1:0]             wb_way;

    // storage ports, address and data shared by all ways
    logic                          data_read;
    logic [LANES_W+OFFSET_W-1:0]   data_raddr;
    logic [31:0]                   data_rdata [WAYS];
    logic [WAYS-1:0]               data_we;
    logic [LANES_W+OFFSET_W-1:0]   data_waddr;
    logic [31:0]                   data_wdata;
    logic                          tag_read;
    logic [LANES_W-1:0]            tag_raddr;
    logic [TAG_W-1:0]              tag_rdata [WAYS];
    logic [WAYS-1:0]               tag_we;

    cache_addr_u                   req_addr;
    cache_addr_u                   line_addr;
    logic [TAG_W-1:0]              req_tag;
    logic [LANES_W-1:0]            req_lane;
    logic [OFFSET_W-1:0]           req_offset;
    logic [1:0]                    req_inword;

    logic                          hit_any;
    logic [WAYS_W-1:0]             hit_way;
    logic [31:0]                   hit_word;
    logic [31:0]                   merged_word;
    logic                          load_misaligned;
    logic                          store_misaligned;
    logic                          misaligned;
    logic                          lookup;
    logic                          victim_dirty;
    logic [LANES_W-1:0]            flush_lane;
    logic [WAYS_W-1:0]             flush_way;
    logic                          start_evict;
    logic                          start_flush_wb;
    logic                          refill_beat;
    logic                          wb_accept;
    logic [OFFSET_W-1:0]           wb_rd_offset;

    assign req_addr.raw = c_address;
    assign req_tag      = req_addr.f.tag;
    assign req_lane     = req_addr.f.lane;
    assign req_offset   = req_addr.f.offset;
    assign req_inword   = req_addr.f.inword;

    assign flush_lane = flush_idx[WAYS_W +: LANES_W];
    assign flush_way  = flush_idx[WAYS_W-1:0];

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        mem_1w1r #(
            .ELEMENTS_W(LANES_W + OFFSET_W),
            .WIDTH(32)
        ) u_data (
            .clk(clk),
            .read(data_read),
            .readaddress(data_raddr),
            .readdata(data_rdata[w]),
            .write(data_we[w]),
            .writeaddress(data_waddr),
            .writedata(data_wdata)
        );

        mem_1w1r #(
            .ELEMENTS_W(LANES_W),
            .WIDTH(TAG_W)
        ) u_tag (
            .clk(clk),
            .read(tag_read),
            .readaddress(tag_raddr),
            .readdata(tag_rdata[w]),
            .write(tag_we[w]),
            .writeaddress(req_lane),
            .writedata(req_tag)
        );
    end

    // tag compare against all ways of the lane
    always_comb begin
        hit_any = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid[w][req_lane] && tag_rdata[w] == req_tag) begin
                hit_any = 1'b1;
                hit_way = WAYS_W'(w);
            end
        end
    end

    assign hit_word = data_rdata[hit_way];

    cache_load_align u_load_align (
        .word(hit_word),
        .inword(req_inword),
        .load_type(c_load_type),
        .data(c_load_data),
        .misaligned(load_misaligned)
    );

    cache_store_merge u_store_merge (
        .old_word(hit_word),
        .store_data(c_store_data),
        .inword(req_inword),
        .store_type(c_store_type),
        .new_word(merged_word),
        .misaligned(store_misaligned)
    );

    assign misaligned     = c_load ? load_misaligned : store_misaligned;
    assign lookup         = (state == STATE_LOOKUP);
    assign victim_dirty   = valid[victim_way][req_lane] && dirty[victim_way][req_lane];
    assign start_evict    = lookup && !misaligned && !hit_any && victim_dirty;
    assign start_flush_wb = (state == STATE_FLUSH_ALL) && flush_rd
                            && valid[flush_way][flush_lane] && dirty[flush_way][flush_lane];
    assign refill_beat    = (state == STATE_REFILL) && cmd_sent && !refill_done
                            && m_readdatavalid;
    assign wb_accept      = (state == STATE_WRITEBACK) && wb_primed && !m_waitrequest;

    assign c_done        = lookup && (misaligned || hit_any);
    assign c_accessfault = lookup && misaligned;
    assign c_wait        = (c_load || c_store) && !c_done;

    // writeback reads run one word ahead of the accepted beat
    assign wb_rd_offset = wb_primed ? beat + 1'b1 : beat;

    always_comb begin
        if (state == STATE_WRITEBACK) begin
            data_raddr = {wb_lane, wb_rd_offset};
            data_read  = !wb_primed || !m_waitrequest;
        end else begin
            data_raddr = {req_lane, req_offset};
            data_read  = (state == STATE_IDLE) || (state == STATE_REFILL && refill_done);
        end
        tag_raddr = (state == STATE_FLUSH_ALL) ? flush_lane : req_lane;
        tag_read  = (state == STATE_IDLE) || (state == STATE_FLUSH_ALL)
                    || (state == STATE_REFILL && refill_done);
    end

    assign data_waddr = {req_lane, (state == STATE_REFILL) ? beat : req_offset};
    assign data_wdata = (state == STATE_REFILL) ? m_readdata : merged_word;

    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            data_we[w] = (lookup && c_store && hit_any && !misaligned && hit_way == WAYS_W'(w))
                         || (refill_beat && victim_way == WAYS_W'(w));
            tag_we[w]  = refill_beat && beat == LAST_BEAT && victim_way == WAYS_W'(w);
        end
    end

    // line base of the current burst
    always_comb begin
        line_addr.f.tag    = (state == STATE_WRITEBACK) ? wb_tag : req_tag;
        line_addr.f.lane   = (state == STATE_WRITEBACK) ? wb_lane : req_lane;
        line_addr.f.offset = '0;
        line_addr.f.inword = '0;
    end

    assign m_address   = line_addr.raw;
    assign m_read      = (state == STATE_REFILL) && !cmd_sent;
    assign m_write     = (state == STATE_WRITEBACK) && wb_primed;
    assign m_writedata = data_rdata[wb_way];

    always_ff @(posedge clk) begin
        if (start_evict) begin
            wb_tag  <= tag_rdata[victim_way];
            wb_lane <= req_lane;
            wb_way  <= victim_way;
        end else if (start_flush_wb) begin
            wb_tag  <= tag_rdata[flush_way];
            wb_lane <= flush_lane;
            wb_way  <= flush_way;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= STATE_IDLE;
            valid         <= '0;
            dirty         <= '0;
            flush_pending <= 1'b0;
            victim_way    <= '0;
            beat          <= '0;
            wb_primed     <= 1'b0;
            cmd_sent      <= 1'b0;
            refill_done   <= 1'b0;
            flush_rd      <= 1'b0;
            flush_idx     <= '0;
            c_flushing    <= 1'b0;
            c_flush_done  <= 1'b0;
        end else begin
            c_flush_done <= 1'b0;
            // flush during a request waits for the next idle cycle
            if (c_flush && state != STATE_IDLE && !c_flushing) begin
                flush_pending <= 1'b1;
            end
            case (state)
                STATE_IDLE: begin
                    if (c_flush || flush_pending) begin
                        state         <= STATE_FLUSH_ALL;
                        c_flushing    <= 1'b1;
                        flush_pending <= 1'b0;
                        flush_idx     <= '0;
                        flush_rd      <= 1'b0;
                    end else if (c_load || c_store) begin
                        state <= STATE_LOOKUP;
                    end
                end
                STATE_LOOKUP: begin
                    beat <= '0;
                    if (misaligned || hit_any) begin
                        state <= STATE_IDLE;
                        if (c_store && !misaligned) begin
                            dirty[hit_way][req_lane] <= 1'b1;
                        end
                    end else if (victim_dirty) begin
                        state     <= STATE_WRITEBACK;
                        wb_primed <= 1'b0;
                    end else begin
                        state       <= STATE_REFILL;
                        cmd_sent    <= 1'b0;
                        refill_done <= 1'b0;
                    end
                end
                STATE_WRITEBACK: begin
                    if (!wb_primed) begin
                        wb_primed <= 1'b1;
                    end else if (wb_accept) begin
                        beat <= beat + 1'b1;
                        if (beat == LAST_BEAT) begin
                            if (c_flushing) begin
                                state    <= STATE_FLUSH_ALL;
                                flush_rd <= 1'b0;
                            end else begin
                                state       <= STATE_REFILL;
                                cmd_sent    <= 1'b0;
                                refill_done <= 1'b0;
                            end
                        end
                    end
                end
                STATE_REFILL: begin
                    if (refill_done) begin
                        state       <= STATE_LOOKUP;
                        refill_done <= 1'b0;
                    end else if (!cmd_sent) begin
                        cmd_sent <= !m_waitrequest;
                    end else if (refill_beat) begin
                        beat <= beat + 1'b1;
                        if (beat == LAST_BEAT) begin
                            refill_done                 <= 1'b1;
                            valid[victim_way][req_lane] <= 1'b1;
                            dirty[victim_way][req_lane] <= 1'b0;
                            victim_way                  <= victim_way + 1'b1;
                        end
                    end
                end
                STATE_FLUSH_ALL: begin
                    if (!flush_rd) begin
                        flush_rd <= 1'b1;
                    end else if (start_flush_wb) begin
                        // entry is revisited clean after the writeback
                        dirty[flush_way][flush_lane] <= 1'b0;
                        state     <= STATE_WRITEBACK;
                        wb_primed <= 1'b0;
                        beat      <= '0;
                    end else if (&flush_idx) begin
                        valid        <= '0;
                        dirty        <= '0;
                        c_flushing   <= 1'b0;
                        c_flush_done <= 1'b1;
                        state        <= STATE_IDLE;
                    end else begin
                        flush_idx <= flush_idx + 1'b1;
                        flush_rd  <= 1'b0;
                    end
                end
                default: begin
                    state <= STATE_IDLE;
                end
            endcase
        end
    end

endmodule

// File: verif/cache_mem_model.sv
`timescale 1ns/10ps

module cache_mem_model #(
    parameter int WORDS_W = 12
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] m_address,
    output logic        m_waitrequest,
    input  logic        m_read,
    output logic [31:0] m_readdata,
    output logic        m_readdatavalid,
    input  logic        m_write,
    input  logic [31:0] m_writedata
);

    // backing store, filled by the testbench
    logic [31:0]        mem [2**WORDS_W];
    logic [WORDS_W-1:0] rd_ptr;
    logic [4:0]         rd_left;
    logic [3:0]         wr_beat;

    always @(posedge clk) begin
        if (!rst_n) begin
            m_waitrequest   <= 1'b1;
            m_readdatavalid <= 1'b0;
            m_readdata      <= '0;
            rd_ptr          <= '0;
            rd_left         <= '0;
            wr_beat         <= '0;
        end else begin
            m_waitrequest <= ($urandom_range(3) == 0);
            // write beats land at line base plus beat number
            if (m_write && !m_waitrequest) begin
                mem[{m_address[WORDS_W+1:6], wr_beat}] <= m_writedata;
                wr_beat <= wr_beat + 1'b1;
            end
            if (m_read && !m_waitrequest && rd_left == 0) begin
                rd_ptr  <= m_address[WORDS_W+1:2];
                rd_left <= 5'd16;
            end
            // read beats with random gaps
            if (rd_left != 0 && $urandom_range(3) != 0) begin
                m_readdatavalid <= 1'b1;
                m_readdata      <= mem[rd_ptr];
                rd_ptr          <= rd_ptr + 1'b1;
                rd_left         <= rd_left - 1'b1;
            end else begin
                m_readdatavalid <= 1'b0;
            end
        end
    end

endmodule

// File: verif/cache_tb.sv
`timescale 1ns/10ps

module cache_tb import armleocpu_defs_pkg::*; ();

    localparam int SEED           = 51;
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int MEM_WORDS      = 4096;
    localparam int MEM_BYTES      = 4 * MEM_WORDS;

    logic        clk = 1'b0;
    logic        rst_n;
    logic [31:0] c_address;
    logic        c_wait;
    logic        c_accessfault;
    logic        c_done;
    logic        c_load;
    load_type_t  c_load_type;
    logic [31:0] c_load_data;
    logic        c_store;
    store_type_t c_store_type;
    logic [31:0] c_store_data;
    logic        c_flush;
    logic        c_flushing;
    logic        c_flush_done;
    logic [31:0] m_address;
    logic        m_waitrequest;
    logic        m_read;
    logic [31:0] m_readdata;
    logic        m_readdatavalid;
    logic        m_write;
    logic [31:0] m_writedata;

    // expected memory contents, byte addressed
    logic [7:0]  shadow [MEM_BYTES];
    int          cycle_count = 0;

    always #4 clk = ~clk;

    armleocpu_cache #(
        .WAYS_W(2),
        .LANES_W(4)
    ) DUT (
        .clk(clk), .rst_n(rst_n),
        .c_address(c_address), .c_wait(c_wait), .c_accessfault(c_accessfault),
        .c_done(c_done), .c_load(c_load), .c_load_type(c_load_type),
        .c_load_data(c_load_data), .c_store(c_store), .c_store_type(c_store_type),
        .c_store_data(c_store_data), .c_flush(c_flush), .c_flushing(c_flushing),
        .c_flush_done(c_flush_done),
        .m_address(m_address), .m_waitrequest(m_waitrequest), .m_read(m_read),
        .m_readdata(m_readdata), .m_readdatavalid(m_readdatavalid),
        .m_write(m_write), .m_writedata(m_writedata)
    );

    cache_mem_model #(
        .WORDS_W(12)
    ) mem_model (
        .clk(clk), .rst_n(rst_n),
        .m_address(m_address), .m_waitrequest(m_waitrequest), .m_read(m_read),
        .m_readdata(m_readdata), .m_readdatavalid(m_readdatavalid),
        .m_write(m_write), .m_writedata(m_writedata)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("** FAIL **");
            $fatal(1, "timeout");
        end
    end

    task automatic check_word(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %h actual %h",
                     $time, name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t: %s expected %b actual %b",
                     $time, name, expected, actual);
            $display("** FAIL **");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] shadow_word(input int idx);
        return {shadow[4*idx+3], shadow[4*idx+2], shadow[4*idx+1], shadow[4*idx]};
    endfunction

    // little endian, sign or zero extended by load type
    function automatic logic [31:0] expected_load(input logic [31:0] addr,
                                                  input load_type_t ltype);
        logic [13:0] a;
        logic [7:0]  b;
        logic [15:0] h;
        a = addr[13:0];
        b = shadow[a];
        h = {shadow[a+1], shadow[a]};
        case (ltype)
            LOAD_BYTE:          return {{24{b[7]}}, b};
            LOAD_BYTE_UNSIGNED: return {24'd0, b};
            LOAD_HALF:          return {{16{h[15]}}, h};
            LOAD_HALF_UNSIGNED: return {16'd0, h};
            default:            return {shadow[a+3], shadow[a+2], h};
        endcase
    endfunction

    function automatic logic load_misaligned(input logic [31:0] addr, input load_type_t ltype);
        if (ltype == LOAD_WORD) begin
            return addr[1:0] != 2'd0;
        end
        return (ltype == LOAD_HALF || ltype == LOAD_HALF_UNSIGNED) && addr[0];
    endfunction

    function automatic logic store_misaligned(input logic [31:0] addr, input store_type_t stype);
        if (stype == STORE_WORD) begin
            return addr[1:0] != 2'd0;
        end
        return stype == STORE_HALF && addr[0];
    endfunction

    task automatic fill_memory();
        logic [31:0] w;
        for (int i = 0; i < MEM_WORDS; i++) begin
            w = $urandom;
            mem_model.mem[i] = w;
            for (int k = 0; k < 4; k++) begin
                shadow[4*i+k] = w[8*k +: 8];
            end
        end
    endtask

    // starts and ends on a falling edge
    task automatic access(input logic is_store, input logic [31:0] addr,
                          input load_type_t ltype, input store_type_t stype,
                          input logic [31:0] sdata, output logic [31:0] data,
                          output logic fault, output int cycles);
        c_address    = addr;
        c_load       = !is_store;
        c_store      = is_store;
        c_load_type  = ltype;
        c_store_type = stype;
        c_store_data = sdata;
        cycles       = 0;
        do begin
            @(negedge clk);
            cycles++;
            // core is held until the done cycle
            check_bit("c_wait", c_done !== 1'b1, c_wait);
        end while (c_done !== 1'b1);
        data  = c_load_data;
        fault = c_accessfault;
        // hold the request until the done cycle has ended
        @(negedge clk);
        c_load  = 1'b0;
        c_store = 1'b0;
    endtask

    task automatic do_load(input logic [31:0] addr, input load_type_t ltype,
                           output int cycles);
        logic [31:0] data;
        logic        fault;
        logic        bad;
        bad = load_misaligned(addr, ltype);
        access(1'b0, addr, ltype, STORE_WORD, 32'd0, data, fault, cycles);
        check_bit("c_accessfault", bad, fault);
        if (!bad) begin
            check_word("c_load_data", expected_load(addr, ltype), data);
        end
    endtask

    task automatic do_store(input logic [31:0] addr, input store_type_t stype,
                            input logic [31:0] sdata, output int cycles);
        logic [31:0] data;
        logic        fault;
        logic        bad;
        int          nbytes;
        bad    = store_misaligned(addr, stype);
        nbytes = (stype == STORE_BYTE) ? 1 : (stype == STORE_HALF) ? 2 : 4;
        access(1'b1, addr, LOAD_WORD, stype, sdata, data, fault, cycles);
        check_bit("c_accessfault", bad, fault);
        if (!bad) begin
            for (int k = 0; k < nbytes; k++) begin
                shadow[addr[13:0] + k] = sdata[8*k +: 8];
            end
        end
    endtask

    task automatic do_flush();
        c_flush = 1'b1;
        @(negedge clk);
        c_flush = 1'b0;
        check_bit("c_flushing", 1'b1, c_flushing);
        do begin
            @(negedge clk);
        end while (c_flush_done !== 1'b1);
        check_bit("c_flushing", 1'b0, c_flushing);
        // exactly one done pulse
        repeat (4) begin
            @(negedge clk);
            check_bit("c_flush_done", 1'b0, c_flush_done);
        end
    endtask

    task automatic test_loads();
        logic [31:0] base;
        int          step;
        int          cycles;
        for (int t = 0; t < 5; t++) begin
            base = 32'h400 + t * 64 + 8;
            step = (t < 2) ? 1 : (t < 4) ? 2 : 4;
            for (int pass = 0; pass < 2; pass++) begin
                for (int off = 0; off < 4; off += step) begin
                    do_load(base + off, load_type_t'(t), cycles);
                    // only the first touch of the line misses
                    check_bit("c_done on hit", pass == 1 || off != 0, cycles == 1);
                end
            end
        end
    endtask

    task automatic test_hit_timing();
        int cycles;
        do_load(32'h400, LOAD_WORD, cycles);
        check_word("load hit latency", 32'd1, 32'(cycles));
        do_store(32'h404, STORE_WORD, 32'h5a5a_0f0f, cycles);
        check_word("store hit latency", 32'd1, 32'(cycles));
        do_load(32'h404, LOAD_WORD, cycles);
        check_word("load hit latency", 32'd1, 32'(cycles));
    endtask

    task automatic test_store_load();
        int cycles;
        do_store(32'h800, STORE_WORD, 32'h1122_3344, cycles);
        do_store(32'h801, STORE_BYTE, 32'h0000_00ab, cycles);
        do_store(32'h802, STORE_HALF, 32'h0000_beef, cycles);
        do_load(32'h800, LOAD_WORD, cycles);
        do_load(32'h802, LOAD_HALF, cycles);
        do_load(32'h800, LOAD_HALF_UNSIGNED, cycles);
        do_load(32'h801, LOAD_BYTE, cycles);
        do_load(32'h803, LOAD_BYTE_UNSIGNED, cycles);
        // store that misses first
        do_store(32'h846, STORE_BYTE, 32'h0000_0080, cycles);
        do_load(32'h844, LOAD_WORD, cycles);
        do_load(32'h846, LOAD_BYTE, cycles);
    endtask

    task automatic test_eviction();
        int cycles;
        // lane 12, five tags, four ways
        for (int k = 0; k < 5; k++) begin
            do_store(32'h310 + k * 32'h400, STORE_WORD, $urandom, cycles);
        end
        for (int i = 0; i < 16; i++) begin
            check_word($sformatf("mem_model.mem[%0d]", 192 + i),
                       shadow_word(192 + i), mem_model.mem[192 + i]);
        end
        for (int k = 0; k < 5; k++) begin
            do_load(32'h310 + k * 32'h400, LOAD_WORD, cycles);
        end
    endtask

    task automatic test_flush();
        int cycles;
        do_flush();
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_word($sformatf("mem_model.mem[%0d]", i), shadow_word(i), mem_model.mem[i]);
        end
        do_load(32'h800, LOAD_WORD, cycles);
        check_bit("c_done later than one cycle", 1'b1, cycles > 1);
    endtask

    task automatic test_misaligned();
        int cycles;
        do_load(32'h900, LOAD_WORD, cycles);
        do_load(32'h901, LOAD_HALF, cycles);
        check_word("fault latency", 32'd1, 32'(cycles));
        do_load(32'h903, LOAD_HALF_UNSIGNED, cycles);
        do_load(32'h902, LOAD_WORD, cycles);
        do_store(32'h905, STORE_HALF, 32'h0000_dead, cycles);
        check_word("fault latency", 32'd1, 32'(cycles));
        do_store(32'h902, STORE_WORD, 32'hffff_ffff, cycles);
        do_load(32'h900, LOAD_WORD, cycles);
        do_load(32'h904, LOAD_WORD, cycles);
        check_word("mem_model.mem[576]", shadow_word(576), mem_model.mem[576]);
        check_word("mem_model.mem[577]", shadow_word(577), mem_model.mem[577]);
    endtask

    initial begin
        void'($urandom(SEED));
        rst_n        = 1'b0;
        c_address    = '0;
        c_load       = 1'b0;
        c_store      = 1'b0;
        c_load_type  = LOAD_WORD;
        c_store_type = STORE_WORD;
        c_store_data = '0;
        c_flush      = 1'b0;
        fill_memory();
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        check_bit("c_done", 1'b0, c_done);
        check_bit("c_accessfault", 1'b0, c_accessfault);
        check_bit("c_flushing", 1'b0, c_flushing);
        check_bit("c_flush_done", 1'b0, c_flush_done);
        check_bit("m_read", 1'b0, m_read);
        check_bit("m_write", 1'b0, m_write);
        test_loads();
        test_hit_timing();
        test_store_load();
        test_eviction();
        test_flush();
        test_misaligned();
        $display("** PASS **");
        $finish;
    end

endmodule

// File: tb.f
logic/armleocpu_defs_pkg.sv
logic/mem_1w1r.sv
logic/cache_load_align.sv
logic/cache_store_merge.sv
logic/armleocpu_cache.sv
verif/cache_mem_model.sv
verif/cache_tb.sv
